// File: cpu_pkg.sv
// pipeline core shared definitions
package cpu_pkg;

	// datapath sizes
	localparam int xlen       = 32; // data and address width
	localparam int reg_addr_w = 5;  // register index width

	// major opcodes
	localparam logic [5:0] op_rtype = 6'b000000; // alu register ops
	localparam logic [5:0] op_addi  = 6'b001000;
	localparam logic [5:0] op_beq   = 6'b000100;

	// r-type function field
	localparam logic [5:0] fn_add = 6'd32;
	localparam logic [5:0] fn_sub = 6'd34;
	localparam logic [5:0] fn_and = 6'd36;
	localparam logic [5:0] fn_or  = 6'd37;
	localparam logic [5:0] fn_nor = 6'd39;
	localparam logic [5:0] fn_slt = 6'd42; // signed compare

	// operation class, decode to execute
	localparam logic [1:0] aluop_add   = 2'b00; // addi
	localparam logic [1:0] aluop_sub   = 2'b01; // beq compare
	localparam logic [1:0] aluop_funct = 2'b10; // look at funct

	// alu control codes
	localparam logic [3:0] alu_and = 4'd0;
	localparam logic [3:0] alu_or  = 4'd1;
	localparam logic [3:0] alu_add = 4'd2;
	localparam logic [3:0] alu_sub = 4'd6;
	localparam logic [3:0] alu_slt = 4'd7;
	localparam logic [3:0] alu_nor = 4'd12;

	// one instruction word, read as r-format or i-format
	typedef union packed {
		struct packed {
			logic [5:0]            opcode;
			logic [reg_addr_w-1:0] rs;
			logic [reg_addr_w-1:0] rt;
			logic [reg_addr_w-1:0] rd;    // destination, r-type
			logic [4:0]            shamt; // unused by this core
			logic [5:0]            funct;
		} r;
		struct packed {
			logic [5:0]            opcode;
			logic [reg_addr_w-1:0] rs;
			logic [reg_addr_w-1:0] rt;    // destination for addi
			logic [15:0]           imm;   // signed immediate or branch offset
		} i;
	} instr_t;

endpackage

// File: reg_file.sv
// integer register file
`timescale 1ns/100ps

module reg_file (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  i_rs,    // read port a
	input  logic [4:0]  i_rt,    // read port b
	input  logic        i_we,    // retire strobe from writeback
	input  logic [4:0]  i_wreg,
	input  logic [31:0] i_wdata,
	output logic [31:0] o_rs_data,
	output logic [31:0] o_rt_data
);

	logic [31:0] regs [32]; // r0 slot kept at zero

	// one read port, write-through when the writeback hits the same register
	function automatic logic [31:0] read_port(input logic [4:0] addr);
		logic [31:0] val;
		if (addr == 5'd0)
			val = '0; // hard zero
		else if (i_we && (addr == i_wreg))
			val = i_wdata; // same-cycle bypass
		else
			val = regs[addr];
		return val;
	endfunction

	// write port
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (i_we && (i_wreg != 5'd0))
			regs[i_wreg] <= i_wdata; // r0 ignores writes
	end

	always_comb
	begin
		o_rs_data = read_port(i_rs);
		o_rt_data = read_port(i_rt);
	end

endmodule

// File: fetch_stage.sv
// instruction fetch stage
`timescale 1ns/100ps

module fetch_stage #(
	parameter int imem_depth = 64 // instruction words, power of two
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              i_stall,
	input  logic                              i_branch_taken,  // redirect from execute
	input  logic [cpu_pkg::xlen-1:0]          i_branch_target,
	input  logic                              i_imem_we,       // program load strobe
	input  logic [$clog2(imem_depth)-1:0]     i_imem_addr,     // word index
	input  cpu_pkg::instr_t                   i_imem_data,
	output cpu_pkg::instr_t                   o_instr,
	output logic [cpu_pkg::xlen-1:0]          o_pc_next,
	output logic                              o_valid
);
	import cpu_pkg::*;

	localparam int idx_w = $clog2(imem_depth); // word index bits

	instr_t          imem [imem_depth]; // instruction store
	logic [xlen-1:0] pc;
	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] pc_sel;
	instr_t          fetched;

	assign pc_plus4 = pc + 'd4;
	assign pc_sel   = i_branch_taken ? i_branch_target : pc_plus4; // taken beq wins
	assign fetched  = imem[pc[idx_w+1:2]]; // byte pc to word index, upper bits wrap

	// load port, works while the core is stalled
	always_ff @(posedge clk)
	begin
		if (i_imem_we)
			imem[i_imem_addr] <= i_imem_data;
	end

	// program counter
	always_ff @(posedge clk)
	begin
		if (!rst)
			pc <= '0; // start at word 0
		else if (!i_stall)
			pc <= pc_sel;
	end

	// if/id valid bit
	always_ff @(posedge clk)
	begin
		if (!rst)
			o_valid <= 1'b0;
		else if (!i_stall)
			o_valid <= !i_branch_taken; // squash the slot behind a taken branch
	end

	// if/id payload
	always_ff @(posedge clk)
	begin
		if (!i_stall)
		begin
			o_instr   <= fetched;
			o_pc_next <= pc_plus4; // branch base is pc plus 4
		end
	end

endmodule

// File: decode_stage.sv
// instruction decode stage
`timescale 1ns/100ps

module decode_stage (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              i_stall,
	input  logic                              i_flush,    // taken branch in execute
	input  cpu_pkg::instr_t                   i_instr,
	input  logic [cpu_pkg::xlen-1:0]          i_pc_next,
	input  logic                              i_valid,
	input  logic                              i_we,       // register file write port
	input  logic [cpu_pkg::reg_addr_w-1:0]    i_wreg,
	input  logic [cpu_pkg::xlen-1:0]          i_wdata,
	output logic [cpu_pkg::xlen-1:0]          o_rs_val,
	output logic [cpu_pkg::xlen-1:0]          o_rt_val,
	output logic [cpu_pkg::xlen-1:0]          o_imm,
	output logic [cpu_pkg::reg_addr_w-1:0]    o_dest,
	output logic                              o_regwrite,
	output logic                              o_alusrc,
	output logic                              o_branch,
	output logic [1:0]                        o_aluop,
	output logic [5:0]                        o_funct,
	output logic [cpu_pkg::xlen-1:0]          o_pc_next,
	output logic                              o_valid
);
	import cpu_pkg::*;

	logic [xlen-1:0]       rs_data;
	logic [xlen-1:0]       rt_data;
	logic [xlen-1:0]       imm_ext;
	logic [reg_addr_w-1:0] dest;
	logic                  regdst;   // rd instead of rt
	logic                  alusrc;   // immediate as operand b
	logic                  regwrite;
	logic                  branch;
	logic [1:0]            aluop;

	reg_file reg_file_inst (
		.clk       (clk),
		.rst       (rst),
		.i_rs      (i_instr.r.rs),
		.i_rt      (i_instr.r.rt),
		.i_we      (i_we),
		.i_wreg    (i_wreg),
		.i_wdata   (i_wdata),
		.o_rs_data (rs_data),
		.o_rt_data (rt_data)
	);

	// main control
	always_comb
	begin
		regdst   = 1'b0;
		alusrc   = 1'b0;
		regwrite = 1'b0;
		branch   = 1'b0;
		aluop    = aluop_add;
		case (i_instr.r.opcode)
			op_rtype:
			begin
				regdst   = 1'b1;
				regwrite = 1'b1;
				aluop    = aluop_funct;
			end
			op_addi:
			begin
				alusrc   = 1'b1;
				regwrite = 1'b1;
			end
			op_beq:
			begin
				branch = 1'b1;
				aluop  = aluop_sub; // equal when difference is zero
			end
			default: regwrite = 1'b0; // anything else runs as a nop
		endcase
	end

	assign imm_ext = {{(xlen-16){i_instr.i.imm[15]}}, i_instr.i.imm}; // copy bit 15 up
	assign dest    = regdst ? i_instr.r.rd : i_instr.i.rt;

	// id/ex control
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			o_valid    <= 1'b0;
			o_regwrite <= 1'b0;
			o_branch   <= 1'b0;
			o_alusrc   <= 1'b0;
			o_aluop    <= aluop_add;
		end
		else if (!i_stall)
		begin
			o_valid    <= i_valid && !i_flush; // second squashed slot
			o_regwrite <= regwrite;
			o_branch   <= branch;
			o_alusrc   <= alusrc;
			o_aluop    <= aluop;
		end
	end

	// id/ex payload
	always_ff @(posedge clk)
	begin
		if (!i_stall)
		begin
			o_rs_val  <= rs_data;
			o_rt_val  <= rt_data;
			o_imm     <= imm_ext;
			o_dest    <= dest;
			o_funct   <= i_instr.r.funct;
			o_pc_next <= i_pc_next;
		end
	end

endmodule

// File: execute_stage.sv
// execute stage with writeback register
`timescale 1ns/100ps

module execute_stage (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              i_stall,
	input  logic [cpu_pkg::xlen-1:0]          i_rs_val,
	input  logic [cpu_pkg::xlen-1:0]          i_rt_val,
	input  logic [cpu_pkg::xlen-1:0]          i_imm,
	input  logic [cpu_pkg::reg_addr_w-1:0]    i_dest,
	input  logic                              i_regwrite,
	input  logic                              i_alusrc,
	input  logic                              i_branch,
	input  logic [1:0]                        i_aluop,
	input  logic [5:0]                        i_funct,
	input  logic [cpu_pkg::xlen-1:0]          i_pc_next,
	input  logic                              i_valid,
	output logic                              o_branch_taken, // redirect and flush
	output logic [cpu_pkg::xlen-1:0]          o_branch_target,
	output logic                              o_we,           // retire strobe
	output logic [cpu_pkg::reg_addr_w-1:0]    o_wreg,
	output logic [cpu_pkg::xlen-1:0]          o_wdata
);
	import cpu_pkg::*;

	logic [3:0]      alu_ctrl;
	logic [xlen-1:0] alu_b;
	logic [xlen-1:0] alu_res;
	logic            we_q; // held while stalled

	// alu control
	always_comb
	begin
		case (i_aluop)
			aluop_add: alu_ctrl = alu_add;
			aluop_sub: alu_ctrl = alu_sub;
			default:
			begin
				case (i_funct)
					fn_add:  alu_ctrl = alu_add;
					fn_sub:  alu_ctrl = alu_sub;
					fn_and:  alu_ctrl = alu_and;
					fn_or:   alu_ctrl = alu_or;
					fn_nor:  alu_ctrl = alu_nor;
					fn_slt:  alu_ctrl = alu_slt;
					default: alu_ctrl = 4'hf; // no op, result zero
				endcase
			end
		endcase
	end

	assign alu_b = i_alusrc ? i_imm : i_rt_val;

	always_comb
	begin
		case (alu_ctrl)
			alu_and: alu_res = i_rs_val & alu_b;
			alu_or:  alu_res = i_rs_val | alu_b;
			alu_add: alu_res = i_rs_val + alu_b;
			alu_sub: alu_res = i_rs_val - alu_b;
			alu_slt: alu_res = ($signed(i_rs_val) < $signed(alu_b)) ? 'd1 : '0;
			alu_nor: alu_res = ~(i_rs_val | alu_b);
			default: alu_res = '0;
		endcase
	end

	// beq resolves here
	assign o_branch_taken  = i_valid && i_branch && (alu_res == '0);
	assign o_branch_target = i_pc_next + {i_imm[xlen-3:0], 2'b00}; // word offset

	// writeback control
	always_ff @(posedge clk)
	begin
		if (!rst)
			we_q <= 1'b0;
		else if (!i_stall)
			we_q <= i_valid && i_regwrite && (i_dest != '0); // r0 never retires
	end

	// writeback payload
	always_ff @(posedge clk)
	begin
		if (!i_stall)
		begin
			o_wreg  <= i_dest;
			o_wdata <= alu_res;
		end
	end

	assign o_we = we_q && !i_stall; // retire once, on the first unstalled cycle

endmodule

// File: cpu_core.sv
// three stage integer pipeline top
`timescale 1ns/100ps

module cpu_core #(
	parameter int imem_depth = 64 // instruction words
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              i_stall,     // freezes every stage
	input  logic                              i_imem_we,
	input  logic [$clog2(imem_depth)-1:0]     i_imem_addr,
	input  cpu_pkg::instr_t                   i_imem_data,
	output logic                              o_wb_valid,  // one pulse per retired write
	output logic [cpu_pkg::reg_addr_w-1:0]    o_wb_reg,
	output logic [cpu_pkg::xlen-1:0]          o_wb_data
);
	import cpu_pkg::*;

	// fetch to decode
	instr_t                f_instr;
	logic [xlen-1:0]       f_pc_next;
	logic                  f_valid;

	// decode to execute
	logic [xlen-1:0]       d_rs_val;
	logic [xlen-1:0]       d_rt_val;
	logic [xlen-1:0]       d_imm;
	logic [reg_addr_w-1:0] d_dest;
	logic                  d_regwrite;
	logic                  d_alusrc;
	logic                  d_branch;
	logic [1:0]            d_aluop;
	logic [5:0]            d_funct;
	logic [xlen-1:0]       d_pc_next;
	logic                  d_valid;

	// execute back to fetch and decode
	logic                  x_taken;
	logic [xlen-1:0]       x_target;

	fetch_stage #(
		.imem_depth (imem_depth)
	) fetch_stage_inst (
		.clk             (clk),
		.rst             (rst),
		.i_stall         (i_stall),
		.i_branch_taken  (x_taken),
		.i_branch_target (x_target),
		.i_imem_we       (i_imem_we),
		.i_imem_addr     (i_imem_addr),
		.i_imem_data     (i_imem_data),
		.o_instr         (f_instr),
		.o_pc_next       (f_pc_next),
		.o_valid         (f_valid)
	);

	decode_stage decode_stage_inst (
		.clk        (clk),
		.rst        (rst),
		.i_stall    (i_stall),
		.i_flush    (x_taken),
		.i_instr    (f_instr),
		.i_pc_next  (f_pc_next),
		.i_valid    (f_valid),
		.i_we       (o_wb_valid), // writeback register drives the write port
		.i_wreg     (o_wb_reg),
		.i_wdata    (o_wb_data),
		.o_rs_val   (d_rs_val),
		.o_rt_val   (d_rt_val),
		.o_imm      (d_imm),
		.o_dest     (d_dest),
		.o_regwrite (d_regwrite),
		.o_alusrc   (d_alusrc),
		.o_branch   (d_branch),
		.o_aluop    (d_aluop),
		.o_funct    (d_funct),
		.o_pc_next  (d_pc_next),
		.o_valid    (d_valid)
	);

	execute_stage execute_stage_inst (
		.clk             (clk),
		.rst             (rst),
		.i_stall         (i_stall),
		.i_rs_val        (d_rs_val),
		.i_rt_val        (d_rt_val),
		.i_imm           (d_imm),
		.i_dest          (d_dest),
		.i_regwrite      (d_regwrite),
		.i_alusrc        (d_alusrc),
		.i_branch        (d_branch),
		.i_aluop         (d_aluop),
		.i_funct         (d_funct),
		.i_pc_next       (d_pc_next),
		.i_valid         (d_valid),
		.o_branch_taken  (x_taken),
		.o_branch_target (x_target),
		.o_we            (o_wb_valid),
		.o_wreg          (o_wb_reg),
		.o_wdata         (o_wb_data)
	);

endmodule

// File: tb_cpu_tests.svh
// directed tests for the pipeline core

function automatic instr_t enc_r(input logic [5:0] funct, input int rd, input int rs,
	input int rt);
	instr_t w;
	w.r.opcode = op_rtype;
	w.r.rs     = 5'(rs);
	w.r.rt     = 5'(rt);
	w.r.rd     = 5'(rd);
	w.r.shamt  = 5'd0;
	w.r.funct  = funct;
	return w;
endfunction

// rt is the addi destination and the second beq operand
function automatic instr_t enc_i(input logic [5:0] op, input int rs, input int rt, input int imm);
	instr_t w;
	w.i.opcode = op;
	w.i.rs     = 5'(rs);
	w.i.rt     = 5'(rt);
	w.i.imm    = 16'(imm);
	return w;
endfunction

function automatic instr_t fill_word(input int addr);
	instr_t w;
	w = {6'h3f, 26'(addr)}; // unknown opcode runs as a nop
	return w;
endfunction

function automatic int rand_imm();
	return int'($urandom_range(65535, 0)) - 32768; // full signed 16-bit range
endfunction

function automatic bit is_alu_funct(input logic [5:0] f);
	return f == fn_add || f == fn_sub || f == fn_and || f == fn_or || f == fn_nor || f == fn_slt;
endfunction

// supported functs in a fixed rotation
function automatic logic [5:0] pick_funct(input int k);
	case (k % 6)
		0:       return fn_add;
		1:       return fn_sub;
		2:       return fn_and;
		3:       return fn_or;
		4:       return fn_nor;
		default: return fn_slt;
	endcase
endfunction

task automatic put(input instr_t w);
	prog.push_back(w);
endtask

// one nop behind each instruction covers the producer to consumer gap
task automatic put_spaced(input instr_t w);
	put(w);
	put(enc_r(6'd0, 0, 0, 0));
endtask

task automatic put_halt();
	put(enc_i(op_beq, 0, 0, -1)); // branch to itself
endtask

task automatic reset_and_addi_chain();
	apply_reset();
	repeat (4)
	begin
		@(negedge clk);
		check_val("o_wb_valid", {31'd0, o_wb_valid}, 32'd0); // quiet while stalled
		step_clock();
	end
	prog.delete();
	put_spaced(enc_i(op_addi, 0, 1, 5));
	put_spaced(enc_i(op_addi, 1, 2, 7));
	put_spaced(enc_i(op_addi, 2, 3, -3));
	put_spaced(enc_i(op_addi, 3, 4, 100));
	put_spaced(enc_i(op_addi, 4, 1, -1));
	put_halt();
	run_program(1'b0);
endtask

task automatic addi_random_imm();
	apply_reset();
	prog.delete();
	repeat (12)
		put_spaced(enc_i(op_addi, $urandom_range(31, 0), $urandom_range(31, 1), rand_imm()));
	put_halt();
	run_program(1'b0);
endtask

task automatic rtype_all_ops();
	logic [5:0] f;
	apply_reset();
	prog.delete();
	for (int r = 1; r <= 8; r++)
		put_spaced(enc_i(op_addi, 0, r, rand_imm())); // operand pool
	for (int k = 0; k < 12; k++)
		put_spaced(enc_r(pick_funct(k), $urandom_range(15, 1), $urandom_range(8, 1),
			$urandom_range(8, 1)));
	do
		f = 6'($urandom);
	while (is_alu_funct(f));
	put_spaced(enc_r(f, $urandom_range(15, 9), 1, 2)); // unsupported funct
	put_spaced(enc_i(op_addi, 0, 9, -5));
	put_spaced(enc_i(op_addi, 0, 10, 3));
	put_spaced(enc_r(fn_slt, 11, 9, 10)); // negative below positive
	put_spaced(enc_r(fn_slt, 12, 10, 9));
	put_halt();
	run_program(1'b0);
endtask

task automatic branch_loop_and_fallthrough();
	int top;
	int b_exit;
	int b_back;
	apply_reset();
	prog.delete();
	put_spaced(enc_i(op_addi, 0, 1, 0));                     // counter
	put_spaced(enc_i(op_addi, 0, 2, $urandom_range(5, 3)));  // trip count
	put_spaced(enc_i(op_addi, 0, 3, 0));
	top = prog.size();
	put_spaced(enc_i(op_addi, 1, 1, 1));
	put_spaced(enc_i(op_addi, 3, 3, 5));
	b_exit = prog.size();
	put(enc_r(6'd0, 0, 0, 0)); // exit branch patched below
	put(enc_r(6'd0, 0, 0, 0));
	b_back = prog.size();
	put(enc_i(op_beq, 0, 0, top - b_back - 1));
	put(enc_i(op_addi, 0, 6, 99)); // both squashed every pass
	put(enc_i(op_addi, 0, 7, 98));
	prog[b_exit] = enc_i(op_beq, 1, 2, prog.size() - b_exit - 1);
	put_spaced(enc_i(op_addi, 0, 4, 1));
	put_spaced(enc_i(op_beq, 1, 0, 2)); // not taken since the counter is nonzero
	put_spaced(enc_i(op_addi, 1, 5, 7));
	put_halt();
	run_program(1'b0);
endtask

task automatic stall_pulse_run();
	apply_reset();
	prog.delete();
	for (int r = 1; r <= 6; r++)
		put_spaced(enc_i(op_addi, 0, r, rand_imm()));
	repeat (14)
	begin
		if ($urandom_range(1, 0) == 0)
			put_spaced(enc_i(op_addi, $urandom_range(6, 1), $urandom_range(12, 1), rand_imm()));
		else
			put_spaced(enc_r(pick_funct($urandom_range(5, 0)), $urandom_range(12, 1),
				$urandom_range(6, 1), $urandom_range(6, 1)));
	end
	put_halt();
	run_program(1'b1); // random freezes while it runs
endtask

task automatic zero_reg_writes();
	apply_reset();
	prog.delete();
	put_spaced(enc_i(op_addi, 0, 1, 25));
	put_spaced(enc_i(op_addi, 0, 2, -9));
	put_spaced(enc_i(op_addi, 1, 0, 123)); // no writeback
	put_spaced(enc_r(fn_add, 0, 1, 2));
	put_spaced(enc_r(fn_or, 0, 1, 2));
	put_spaced(enc_r(fn_add, 8, 0, 0));     // r0 still reads zero
	put_spaced(enc_r(fn_or, 9, 0, 1));
	put_spaced(enc_i(op_addi, 0, 10, 0));
	put_halt();
	run_program(1'b0);
endtask

// File: tb_cpu_core.sv
// pipeline core testbench
`timescale 1ns/100ps

module tb_cpu_core;
	import cpu_pkg::*;

	localparam int imem_depth = 64;
	localparam int addr_w     = $clog2(imem_depth);
	localparam int step_cap   = 2000; // runaway guard for the golden model

	logic                  clk;
	logic                  rst;
	logic                  i_stall;
	logic                  i_imem_we;
	logic [addr_w-1:0]     i_imem_addr;
	instr_t                i_imem_data;
	logic                  o_wb_valid;
	logic [reg_addr_w-1:0] o_wb_reg;
	logic [xlen-1:0]       o_wb_data;

	instr_t      prog [$];     // program under test from word 0
	logic [4:0]  exp_reg [$];  // expected writes in retire order
	logic [31:0] exp_data [$];
	logic [31:0] gold_regs [32];
	logic [4:0]  mon_reg;
	logic [31:0] mon_data;
	int          checks       = 0;
	int          mismatches   = 0;
	int          other_errors = 0;
	int          cycle_count  = 0;
	int          cycle_limit  = 100; // grows as each program is scheduled

	cpu_core #(
		.imem_depth (imem_depth)
	) cpu_core_inst (
		.clk         (clk),
		.rst         (rst),
		.i_stall     (i_stall),
		.i_imem_we   (i_imem_we),
		.i_imem_addr (i_imem_addr),
		.i_imem_data (i_imem_data),
		.o_wb_valid  (o_wb_valid),
		.o_wb_reg    (o_wb_reg),
		.o_wb_data   (o_wb_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			mismatches++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_fault(input string msg);
		other_errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic step_clock();
		@(posedge clk);
		#2; // drive point
	endtask

	// core held frozen through and after reset
	task automatic apply_reset();
		i_stall = 1'b1;
		rst     = 1'b0;
		repeat (2) step_clock();
		rst     = 1'b1;
	endtask

	task automatic expect_write(input logic [4:0] dst, input logic [31:0] val);
		if (dst != 5'd0) // r0 never retires
		begin
			gold_regs[dst] = val;
			exp_reg.push_back(dst);
			exp_data.push_back(val);
		end
	endtask

	// isa rules for the r-type functions
	function automatic logic [31:0] r_rule(input logic [5:0] f, input logic [31:0] a,
		input logic [31:0] b);
		case (f)
			fn_add:  return a + b;
			fn_sub:  return a - b;
			fn_and:  return a & b;
			fn_or:   return a | b;
			fn_nor:  return ~(a | b);
			fn_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return 32'd0; // unsupported funct writes zero
		endcase
	endfunction

	// golden interpreter with sequential semantics and no visible squash
	task automatic build_expected(output int steps);
		instr_t      ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_s;
		int          idx;
		int          offs;
		bit          done;
		for (int i = 0; i < 32; i++)
			gold_regs[i] = 32'd0; // reset clears the register file
		exp_reg.delete();
		exp_data.delete();
		idx   = 0;
		steps = 0;
		done  = 1'b0;
		while (!done)
		begin
			if (idx >= prog.size() || steps > step_cap)
			begin
				report_fault("golden model ran past the program without a halt");
				done = 1'b1;
			end
			else
			begin
				ins   = prog[idx];
				a     = gold_regs[ins.r.rs];
				b     = gold_regs[ins.r.rt];
				imm_s = {{16{ins.i.imm[15]}}, ins.i.imm};
				steps++;
				idx++;
				case (ins.r.opcode)
					op_rtype: expect_write(ins.r.rd, r_rule(ins.r.funct, a, b));
					op_addi:  expect_write(ins.i.rt, a + imm_s);
					op_beq:
					begin
						if (a == b)
						begin
							offs = imm_s; // word offset from pc plus 4
							done = (offs == -1); // self loop ends the program
							idx  = idx + offs;
						end
					end
					default: ; // unknown opcode is a nop
				endcase
			end
		end
	endtask

	// whole memory written with address tagged nops past the program
	task automatic load_program();
		if (prog.size() > imem_depth)
			report_fault("program does not fit in instruction memory");
		for (int a = 0; a < imem_depth; a++)
		begin
			i_imem_we   = 1'b1;
			i_imem_addr = addr_w'(a);
			i_imem_data = (a < prog.size()) ? prog[a] : fill_word(a);
			step_clock();
		end
		i_imem_we = 1'b0;
	endtask

	task automatic run_program(input bit stall_pulses);
		int steps;
		int waited;
		load_program();
		build_expected(steps);
		cycle_limit += imem_depth + 10 * steps + 60;
		i_stall = 1'b0;
		waited  = 0;
		while (exp_reg.size() != 0 && waited < 10 * steps + 40)
		begin
			step_clock();
			waited++;
			if (stall_pulses)
				i_stall = ($urandom_range(3, 0) == 0); // about one cycle in four
		end
		i_stall = 1'b0;
		if (exp_reg.size() != 0)
		begin
			report_fault($sformatf("%0d expected writebacks are missing", exp_reg.size()));
			exp_reg.delete();
			exp_data.delete();
		end
		repeat (8) step_clock(); // room for stray pulses
		i_stall = 1'b1;
	endtask

	// writeback monitor sampled mid cycle
	always @(negedge clk)
	begin
		if (rst && o_wb_valid)
		begin
			if (i_stall)
				report_fault("writeback pulse while the core is stalled");
			if (o_wb_reg == '0)
				report_fault("writeback to register 0");
			if (exp_reg.size() == 0)
				report_fault("writeback with no expected write left");
			else
			begin
				mon_reg  = exp_reg.pop_front();
				mon_data = exp_data.pop_front();
				check_val("o_wb_reg", {27'd0, o_wb_reg}, {27'd0, mon_reg});
				check_val("o_wb_data", o_wb_data, mon_data);
			end
		end
	end

	// watchdog
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > cycle_limit)
		begin
			$display("timeout: run went past its limit of %0d cycles", cycle_limit);
			$display("summary: checks %0d, mismatches %0d, other errors %0d",
				checks, mismatches, other_errors + 1);
			$display("=== FAIL ===");
			$finish;
		end
	end

	`include "tb_cpu_tests.svh"

	initial
	begin
		rst         = 1'b0;
		i_stall     = 1'b1;
		i_imem_we   = 1'b0;
		i_imem_addr = '0;
		i_imem_data = '0;
		void'($urandom(32'ha229_1724));
		step_clock();
		reset_and_addi_chain();
		addi_random_imm();
		rtype_all_ops();
		branch_loop_and_fallthrough();
		stall_pulse_run();
		zero_reg_writes();
		$display("summary: checks %0d, mismatches %0d, other errors %0d",
			checks, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: project.f
+incdir+.
cpu_pkg.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
cpu_core.sv
tb_cpu_core.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the pipeline core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_cpu_core -o sim_cpu_core
./obj_dir/sim_cpu_core | tee sim.log

if grep -q "=== FAIL ===" sim.log
then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation finished without failures"
